/* Bender.yml */
package:
  name: rv64_ex

sources:
  - files:
      - rtl/ex_pkg.sv
      - rtl/ex_decoder.sv
      - rtl/ex_alu.sv
      - rtl/ex_branch_unit.sv
      - rtl/ex_csr_unit.sv
      - rtl/ex_result_reg.sv
      - rtl/ex_stage.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/ex_stage_tb.sv

/* rtl/ex_alu.sv */
`timescale 1ns/1ps

module ex_alu
	import ex_pkg::*;
(
	input  alu_op_e         alu_op_i,
	input  logic [XLEN-1:0] op1_i,
	input  logic [XLEN-1:0] op2_i,
	output logic [XLEN-1:0] result_o
);

	// 64 bit shifts take 6 bits, word shifts 5
	logic [5:0]  shamt;
	logic [4:0]  shamt_w;
	logic [31:0] res_w;
	logic        is_word;

	assign shamt   = op2_i[5:0];
	assign shamt_w = op2_i[4:0];
	assign is_word = alu_op_i inside {ADDW, SUBW, SLLW, SRLW, SRAW};

	// low half for the W group
	always_comb begin
		case (alu_op_i)
			ADDW:    res_w = op1_i[31:0] + op2_i[31:0];
			SUBW:    res_w = op1_i[31:0] - op2_i[31:0];
			SLLW:    res_w = op1_i[31:0] << shamt_w;
			SRLW:    res_w = op1_i[31:0] >> shamt_w;
			SRAW:    res_w = $signed(op1_i[31:0]) >>> shamt_w;
			default: res_w = '0;
		endcase
	end

	always_comb begin
		result_o = '0;
		case (alu_op_i)
			ADD:      result_o = op1_i + op2_i;
			SUB:      result_o = op1_i - op2_i;
			SLL:      result_o = op1_i << shamt;
			SLT:      result_o = {{(XLEN-1){1'b0}}, $signed(op1_i) < $signed(op2_i)};
			SLTU:     result_o = {{(XLEN-1){1'b0}}, op1_i < op2_i};
			XOR:      result_o = op1_i ^ op2_i;
			SRL:      result_o = op1_i >> shamt;
			// sign comes from bit 63
			SRA:      result_o = $signed(op1_i) >>> shamt;
			OR:       result_o = op1_i | op2_i;
			AND:      result_o = op1_i & op2_i;
			PASS_OP1: result_o = op1_i;
			default:  result_o = '0;
		endcase
		// word results are sign extended from bit 31
		if (is_word)
			result_o = {{(XLEN-32){res_w[31]}}, res_w};
	end

endmodule

/* rtl/ex_branch_unit.sv */
`timescale 1ns/1ps

module ex_branch_unit
	import ex_pkg::*;
(
	input  br_kind_e        br_kind_i,
	input  logic [XLEN-1:0] op1_i,
	input  logic [XLEN-1:0] op2_i,
	input  logic [XLEN-1:0] base_addr_i,
	input  logic [XLEN-1:0] addr_offset_i,
	output logic            taken_o,
	output logic [XLEN-1:0] target_o
);

	logic eq;
	logic lt_s;
	logic lt_u;

	assign eq   = (op1_i == op2_i);
	assign lt_s = ($signed(op1_i) < $signed(op2_i));
	assign lt_u = (op1_i < op2_i);

	always_comb begin
		case (br_kind_i)
			BR_EQ:     taken_o = eq;
			BR_NE:     taken_o = !eq;
			BR_LT:     taken_o = lt_s;
			BR_GE:     taken_o = !lt_s;
			BR_LTU:    taken_o = lt_u;
			BR_GEU:    taken_o = !lt_u;
			// jal and jalr
			BR_ALWAYS: taken_o = 1'b1;
			default:   taken_o = 1'b0;
		endcase
	end

	// target only meaningful when taken
	assign target_o = taken_o ? base_addr_i + addr_offset_i : '0;

endmodule

/* rtl/ex_csr_unit.sv */
`timescale 1ns/1ps

module ex_csr_unit
	import ex_pkg::*;
(
	input  csr_op_e         csr_op_i,
	input  logic [XLEN-1:0] op1_i,
	input  logic [4:0]      uimm_i,
	input  logic [XLEN-1:0] csr_rdata_i,
	output logic [XLEN-1:0] csr_wdata_o
);

	// immediate forms swap rs1 for the zero extended uimm
	logic            use_imm;
	logic [XLEN-1:0] src;

	assign use_imm = csr_op_i inside {CSR_RWI, CSR_RSI, CSR_RCI};
	assign src     = use_imm ? {{(XLEN-5){1'b0}}, uimm_i} : op1_i;

	always_comb begin
		case (csr_op_i)
			CSR_RW, CSR_RWI: csr_wdata_o = src;
			// set bits
			CSR_RS, CSR_RSI: csr_wdata_o = csr_rdata_i | src;
			// clear bits
			CSR_RC, CSR_RCI: csr_wdata_o = csr_rdata_i & ~src;
			default:         csr_wdata_o = '0;
		endcase
	end

endmodule

/* rtl/ex_decoder.sv */
`timescale 1ns/1ps

module ex_decoder
	import ex_pkg::*;
(
	input  logic [31:0] inst_i,
	output alu_op_e     alu_op_o,
	output br_kind_e    br_kind_o,
	output csr_op_e     csr_op_o,
	output wb_sel_e     wb_sel_o
);

	rv_opcode_e opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	// funct7 marks sub or arithmetic shift
	logic       alt;
	// legal funct7 for register and word forms
	logic       f7_ok;
	// rv64 immediate shifts carry a 6 bit shamt so only funct6 is checked
	logic       sh6_ok;
	logic       word_f3;

	assign opcode  = rv_opcode_e'(inst_i[6:0]);
	assign funct3  = inst_i[14:12];
	assign funct7  = inst_i[31:25];
	assign alt     = (funct7 == FUNCT7_ALT);
	assign f7_ok   = (funct7 == FUNCT7_BASE) || (alt && (funct3 == F3_ADD_SUB || funct3 == F3_SR));
	assign sh6_ok  = (inst_i[31:26] == FUNCT7_BASE[6:1]) ||
	                 ((inst_i[31:26] == FUNCT7_ALT[6:1]) && (funct3 == F3_SR));
	assign word_f3 = (funct3 == F3_ADD_SUB) || (funct3 == F3_SLL) || (funct3 == F3_SR);

	always_comb begin
		// unsupported encodings fall through with no effect
		alu_op_o  = ADD;
		br_kind_o = BR_NONE;
		csr_op_o  = CSR_NONE;
		wb_sel_o  = WB_NONE;
		case (opcode)
			OPC_OP, OPC_OP_IMM: begin
				// immediate form only constrains the shift encodings
				if (opcode == OPC_OP ? f7_ok : ((funct3 != F3_SLL && funct3 != F3_SR) || sh6_ok)) begin
					wb_sel_o = WB_ALU;
					case (funct3)
						F3_ADD_SUB: alu_op_o = (opcode == OPC_OP && alt) ? SUB : ADD;
						F3_SLL:     alu_op_o = SLL;
						F3_SLT:     alu_op_o = SLT;
						F3_SLTU:    alu_op_o = SLTU;
						F3_XOR:     alu_op_o = XOR;
						F3_SR:      alu_op_o = funct7[5] ? SRA : SRL;
						F3_OR:      alu_op_o = OR;
						default:    alu_op_o = AND;
					endcase
				end
			end
			OPC_OP_32, OPC_OP_IMM_32: begin
				// addiw keeps immediate bits where funct7 would sit
				if (word_f3 && ((opcode == OPC_OP_IMM_32 && funct3 == F3_ADD_SUB) || f7_ok)) begin
					wb_sel_o = WB_ALU;
					case (funct3)
						F3_ADD_SUB: alu_op_o = (opcode == OPC_OP_32 && alt) ? SUBW : ADDW;
						F3_SLL:     alu_op_o = SLLW;
						default:    alu_op_o = alt ? SRAW : SRLW;
					endcase
				end
			end
			OPC_BRANCH: begin
				case (funct3)
					F3_BEQ:  br_kind_o = BR_EQ;
					F3_BNE:  br_kind_o = BR_NE;
					F3_BLT:  br_kind_o = BR_LT;
					F3_BGE:  br_kind_o = BR_GE;
					F3_BLTU: br_kind_o = BR_LTU;
					F3_BGEU: br_kind_o = BR_GEU;
					default: br_kind_o = BR_NONE;
				endcase
			end
			OPC_JAL, OPC_JALR: begin
				// link value pc + 4 arrives as op1 + op2 from decode
				if (opcode == OPC_JAL || funct3 == 3'b000) begin
					wb_sel_o  = WB_ALU;
					br_kind_o = BR_ALWAYS;
				end
			end
			OPC_LUI: begin
				alu_op_o = PASS_OP1;
				wb_sel_o = WB_ALU;
			end
			OPC_AUIPC: wb_sel_o = WB_ALU;
			OPC_SYSTEM: begin
				case (funct3)
					F3_CSRRW:  csr_op_o = CSR_RW;
					F3_CSRRS:  csr_op_o = CSR_RS;
					F3_CSRRC:  csr_op_o = CSR_RC;
					F3_CSRRWI: csr_op_o = CSR_RWI;
					F3_CSRRSI: csr_op_o = CSR_RSI;
					F3_CSRRCI: csr_op_o = CSR_RCI;
					default:   csr_op_o = CSR_NONE;
				endcase
				// old csr value goes back to rd
				if (funct3[1:0] != 2'b00)
					wb_sel_o = WB_CSR;
			end
			default: ;
		endcase
	end

	// csr write-back and csr operation always come as a pair
	always_comb begin
		assert #0 ((wb_sel_o == WB_CSR) == (csr_op_o != CSR_NONE))
			else $error("decoder: wb_sel and csr_op out of step");
	end

endmodule

/* rtl/ex_pkg.sv */
package ex_pkg;

	// architectural widths
	localparam int XLEN       = 64;
	localparam int REG_ADDR_W = 5;
	localparam int CSR_ADDR_W = 12;

	// funct7 values accepted on register forms
	localparam logic [6:0] FUNCT7_BASE = 7'h00;
	localparam logic [6:0] FUNCT7_ALT  = 7'h20;

	// funct3 for arithmetic and logic
	localparam logic [2:0] F3_ADD_SUB = 3'b000;
	localparam logic [2:0] F3_SLL     = 3'b001;
	localparam logic [2:0] F3_SLT     = 3'b010;
	localparam logic [2:0] F3_SLTU    = 3'b011;
	localparam logic [2:0] F3_XOR     = 3'b100;
	localparam logic [2:0] F3_SR      = 3'b101;
	localparam logic [2:0] F3_OR      = 3'b110;

	// funct3 for conditional branches
	localparam logic [2:0] F3_BEQ  = 3'b000;
	localparam logic [2:0] F3_BNE  = 3'b001;
	localparam logic [2:0] F3_BLT  = 3'b100;
	localparam logic [2:0] F3_BGE  = 3'b101;
	localparam logic [2:0] F3_BLTU = 3'b110;
	localparam logic [2:0] F3_BGEU = 3'b111;

	// funct3 for zicsr
	localparam logic [2:0] F3_CSRRW  = 3'b001;
	localparam logic [2:0] F3_CSRRS  = 3'b010;
	localparam logic [2:0] F3_CSRRC  = 3'b011;
	localparam logic [2:0] F3_CSRRWI = 3'b101;
	localparam logic [2:0] F3_CSRRSI = 3'b110;
	localparam logic [2:0] F3_CSRRCI = 3'b111;

	typedef enum logic [6:0] {
		OPC_OP_IMM    = 7'b0010011,
		OPC_OP        = 7'b0110011,
		OPC_OP_IMM_32 = 7'b0011011,
		OPC_OP_32     = 7'b0111011,
		OPC_BRANCH    = 7'b1100011,
		OPC_JAL       = 7'b1101111,
		OPC_JALR      = 7'b1100111,
		OPC_LUI       = 7'b0110111,
		OPC_AUIPC     = 7'b0010111,
		OPC_SYSTEM    = 7'b1110011
	} rv_opcode_e;

	typedef enum logic [4:0] {
		ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND,
		ADDW, SUBW, SLLW, SRLW, SRAW, PASS_OP1
	} alu_op_e;

	typedef enum logic [2:0] {
		BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU, BR_ALWAYS
	} br_kind_e;

	typedef enum logic [2:0] {
		CSR_NONE, CSR_RW, CSR_RS, CSR_RC, CSR_RWI, CSR_RSI, CSR_RCI
	} csr_op_e;

	typedef enum logic [1:0] {
		WB_NONE, WB_ALU, WB_CSR
	} wb_sel_e;

endpackage

/* rtl/ex_result_reg.sv */
`timescale 1ns/1ps

module ex_result_reg
	import ex_pkg::*;
(
	input  logic                  clk_i,
	input  logic                  rst_n_i,
	input  logic                  in_valid_i,
	output logic                  in_ready_o,
	input  logic                  out_ready_i,
	output logic                  out_valid_o,
	input  wb_sel_e               wb_sel_i,
	input  logic [XLEN-1:0]       alu_result_i,
	input  logic [XLEN-1:0]       csr_rdata_i,
	input  logic [REG_ADDR_W-1:0] rd_addr_i,
	input  logic                  csr_we_i,
	input  logic [CSR_ADDR_W-1:0] csr_waddr_i,
	input  logic [XLEN-1:0]       csr_wdata_i,
	input  logic                  taken_i,
	input  logic [XLEN-1:0]       target_i,
	input  logic                  int_assert_i,
	input  logic [XLEN-1:0]       int_addr_i,
	output logic [REG_ADDR_W-1:0] rd_addr_o,
	output logic [XLEN-1:0]       rd_data_o,
	output logic                  rd_wen_o,
	output logic                  csr_we_o,
	output logic [CSR_ADDR_W-1:0] csr_waddr_o,
	output logic [XLEN-1:0]       csr_wdata_o,
	output logic                  jump_en_o,
	output logic [XLEN-1:0]       jump_addr_o
);

	logic            load;
	logic [XLEN-1:0] rd_data_d;

	// write-back source mux
	always_comb begin
		case (wb_sel_i)
			WB_ALU:  rd_data_d = alu_result_i;
			WB_CSR:  rd_data_d = csr_rdata_i;
			default: rd_data_d = '0;
		endcase
	end

	// empty slot or slot drained this cycle
	assign in_ready_o = !out_valid_o || out_ready_i;
	assign load       = in_valid_i && in_ready_o;

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			out_valid_o <= 1'b0;
			rd_wen_o    <= 1'b0;
			csr_we_o    <= 1'b0;
			jump_en_o   <= 1'b0;
		end else begin
			if (in_ready_o)
				out_valid_o <= in_valid_i;
			if (load) begin
				// interrupt kills both writes and redirects fetch
				rd_wen_o  <= (wb_sel_i != WB_NONE) && !int_assert_i;
				csr_we_o  <= csr_we_i && !int_assert_i;
				jump_en_o <= taken_i || int_assert_i;
			end
		end
	end

	// payload
	always_ff @(posedge clk_i) begin
		if (load) begin
			rd_addr_o   <= rd_addr_i;
			rd_data_o   <= rd_data_d;
			csr_waddr_o <= csr_waddr_i;
			csr_wdata_o <= csr_wdata_i;
			jump_addr_o <= int_assert_i ? int_addr_i : target_i;
		end
	end

	// stalled result stays put until downstream takes it
	assert property (@(posedge clk_i) disable iff (!rst_n_i)
		out_valid_o && !out_ready_i |=> out_valid_o && $stable({rd_addr_o, rd_data_o,
			rd_wen_o, csr_we_o, csr_waddr_o, csr_wdata_o, jump_en_o, jump_addr_o}))
		else $error("result register changed under back-pressure");

	// first edge out of reset sees an empty slot
	assert property (@(posedge clk_i) $rose(rst_n_i) |->
		!out_valid_o && !rd_wen_o && !csr_we_o && !jump_en_o)
		else $error("result register not clear after reset");

endmodule

/* rtl/ex_stage.sv */
`timescale 1ns/1ps

module ex_stage
	import ex_pkg::*;
(
	input  logic                  clk_i,
	input  logic                  rst_n_i,
	input  logic                  in_valid_i,
	output logic                  in_ready_o,
	input  logic [31:0]           inst_i,
	input  logic [XLEN-1:0]       op1_i,
	input  logic [XLEN-1:0]       op2_i,
	input  logic [REG_ADDR_W-1:0] rd_addr_i,
	input  logic [XLEN-1:0]       base_addr_i,
	input  logic [XLEN-1:0]       addr_offset_i,
	input  logic                  csr_we_i,
	input  logic [CSR_ADDR_W-1:0] csr_waddr_i,
	input  logic [XLEN-1:0]       csr_rdata_i,
	input  logic                  int_assert_i,
	input  logic [XLEN-1:0]       int_addr_i,
	input  logic                  out_ready_i,
	output logic                  out_valid_o,
	output logic [REG_ADDR_W-1:0] rd_addr_o,
	output logic [XLEN-1:0]       rd_data_o,
	output logic                  rd_wen_o,
	output logic                  csr_we_o,
	output logic [CSR_ADDR_W-1:0] csr_waddr_o,
	output logic [XLEN-1:0]       csr_wdata_o,
	output logic                  jump_en_o,
	output logic [XLEN-1:0]       jump_addr_o
);

	alu_op_e         alu_op;
	br_kind_e        br_kind;
	csr_op_e         csr_op;
	wb_sel_e         wb_sel;
	logic [XLEN-1:0] alu_result;
	logic            taken;
	logic [XLEN-1:0] target;
	logic [XLEN-1:0] csr_wdata;

	ex_decoder u_decoder (
		.inst_i    (inst_i),
		.alu_op_o  (alu_op),
		.br_kind_o (br_kind),
		.csr_op_o  (csr_op),
		.wb_sel_o  (wb_sel)
	);

	ex_alu u_alu (
		.alu_op_i (alu_op),
		.op1_i    (op1_i),
		.op2_i    (op2_i),
		.result_o (alu_result)
	);

	ex_branch_unit u_branch (
		.br_kind_i     (br_kind),
		.op1_i         (op1_i),
		.op2_i         (op2_i),
		.base_addr_i   (base_addr_i),
		.addr_offset_i (addr_offset_i),
		.taken_o       (taken),
		.target_o      (target)
	);

	// uimm sits in the rs1 field
	ex_csr_unit u_csr (
		.csr_op_i    (csr_op),
		.op1_i       (op1_i),
		.uimm_i      (inst_i[19:15]),
		.csr_rdata_i (csr_rdata_i),
		.csr_wdata_o (csr_wdata)
	);

	ex_result_reg u_result (
		.clk_i        (clk_i),
		.rst_n_i      (rst_n_i),
		.in_valid_i   (in_valid_i),
		.in_ready_o   (in_ready_o),
		.out_ready_i  (out_ready_i),
		.out_valid_o  (out_valid_o),
		.wb_sel_i     (wb_sel),
		.alu_result_i (alu_result),
		.csr_rdata_i  (csr_rdata_i),
		.rd_addr_i    (rd_addr_i),
		.csr_we_i     (csr_we_i),
		.csr_waddr_i  (csr_waddr_i),
		.csr_wdata_i  (csr_wdata),
		.taken_i      (taken),
		.target_i     (target),
		.int_assert_i (int_assert_i),
		.int_addr_i   (int_addr_i),
		.rd_addr_o    (rd_addr_o),
		.rd_data_o    (rd_data_o),
		.rd_wen_o     (rd_wen_o),
		.csr_we_o     (csr_we_o),
		.csr_waddr_o  (csr_waddr_o),
		.csr_wdata_o  (csr_wdata_o),
		.jump_en_o    (jump_en_o),
		.jump_addr_o  (jump_addr_o)
	);

endmodule

/* rv64_ex.f */
+incdir+include
rtl/ex_pkg.sv
rtl/ex_decoder.sv
rtl/ex_alu.sv
rtl/ex_branch_unit.sv
rtl/ex_csr_unit.sv
rtl/ex_result_reg.sv
rtl/ex_stage.sv
verif/ex_stage_tb.sv

/* include/ex_tb_ref.svh */
`ifndef EX_TB_REF_SVH
`define EX_TB_REF_SVH

// golden alu, word selects the W group with sign extension
function automatic logic [XLEN-1:0] ex_ref_alu(
	input logic [2:0]      f3,
	input logic            alt,
	input logic            word,
	input logic [XLEN-1:0] a,
	input logic [XLEN-1:0] b
);
	logic [XLEN-1:0] r;
	logic [31:0]     w;
	case (f3)
		3'd0: r = alt ? a - b : a + b;
		3'd1: r = a << b[5:0];
		3'd2: r = XLEN'($signed(a) < $signed(b));
		3'd3: r = XLEN'(a < b);
		3'd4: r = a ^ b;
		3'd6: r = a | b;
		3'd7: r = a & b;
		default: begin
			if (alt)
				r = $signed(a) >>> b[5:0];
			else
				r = a >> b[5:0];
		end
	endcase
	case (f3)
		3'd0: w = alt ? a[31:0] - b[31:0] : a[31:0] + b[31:0];
		3'd1: w = a[31:0] << b[4:0];
		default: begin
			if (alt)
				w = $signed(a[31:0]) >>> b[4:0];
			else
				w = a[31:0] >> b[4:0];
		end
	endcase
	return word ? {{(XLEN-32){w[31]}}, w} : r;
endfunction

// expected stage output for one accepted transaction
function automatic void ex_ref_result(
	input  logic [31:0]     inst,
	input  logic [XLEN-1:0] op1,
	input  logic [XLEN-1:0] op2,
	input  logic [XLEN-1:0] base,
	input  logic [XLEN-1:0] offset,
	input  logic [XLEN-1:0] csr_rdata,
	input  logic            csr_we,
	input  logic            int_assert,
	input  logic [XLEN-1:0] int_addr,
	output logic            rd_wen,
	output logic [XLEN-1:0] rd_data,
	output logic            csr_we_exp,
	output logic [XLEN-1:0] csr_wdata,
	output logic            jump_en,
	output logic [XLEN-1:0] jump_addr
);
	logic [6:0]      opc;
	logic [2:0]      f3;
	logic [6:0]      f7;
	logic [XLEN-1:0] src;
	logic            ok;
	logic            taken;
	opc       = inst[6:0];
	f3        = inst[14:12];
	f7        = inst[31:25];
	src       = f3[2] ? {{(XLEN-5){1'b0}}, inst[19:15]} : op1;
	ok        = 1'b0;
	taken     = 1'b0;
	rd_data   = '0;
	csr_wdata = '0;
	case (opc)
		OPC_OP: begin
			ok      = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
			rd_data = ex_ref_alu(f3, f7[5], 1'b0, op1, op2);
		end
		OPC_OP_IMM: begin
			ok = !(f3 == 3'd1 || f3 == 3'd5) || inst[31:26] == 6'h00 ||
			     (f3 == 3'd5 && inst[31:26] == 6'h10);
			rd_data = ex_ref_alu(f3, f3 == 3'd5 && inst[30], 1'b0, op1, op2);
		end
		OPC_OP_32, OPC_OP_IMM_32: begin
			ok = (f3 == 3'd0 || f3 == 3'd1 || f3 == 3'd5) && ((opc == OPC_OP_IMM_32 && f3 == 3'd0)
			     || f7 == 7'h00 || (f7 == 7'h20 && f3 != 3'd1));
			rd_data = ex_ref_alu(f3, f7[5] && (f3 == 3'd5 || opc == OPC_OP_32), 1'b1, op1, op2);
		end
		OPC_LUI: begin
			ok      = 1'b1;
			rd_data = op1;
		end
		OPC_AUIPC: begin
			ok      = 1'b1;
			rd_data = op1 + op2;
		end
		OPC_JAL, OPC_JALR: begin
			ok      = (opc == OPC_JAL) || (f3 == 3'd0);
			taken   = ok;
			rd_data = op1 + op2;
		end
		OPC_BRANCH: begin
			case (f3)
				3'd0: taken = (op1 == op2);
				3'd1: taken = (op1 != op2);
				3'd4: taken = ($signed(op1) < $signed(op2));
				3'd5: taken = ($signed(op1) >= $signed(op2));
				3'd6: taken = (op1 < op2);
				3'd7: taken = (op1 >= op2);
				default: taken = 1'b0;
			endcase
		end
		OPC_SYSTEM: begin
			if (f3 != 3'd0 && f3 != 3'd4) begin
				ok      = 1'b1;
				rd_data = csr_rdata;
				case (f3[1:0])
					2'd1: csr_wdata = src;
					2'd2: csr_wdata = csr_rdata | src;
					default: csr_wdata = csr_rdata & ~src;
				endcase
			end
		end
		default: ;
	endcase
	if (!ok)
		rd_data = '0;
	rd_wen     = ok && !int_assert;
	csr_we_exp = csr_we && !int_assert;
	jump_en    = taken || int_assert;
	jump_addr  = int_assert ? int_addr : (taken ? base + offset : '0);
endfunction

`endif

/* verif/ex_stage_tb.sv */
`timescale 1ns/1ps

module ex_stage_tb
	import ex_pkg::*;
();

	`include "ex_tb_ref.svh"

	localparam int NUM_TXN    = 600;
	localparam int WAIT_LIMIT = 64;

	// one expected output transfer
	typedef struct packed {
		logic [REG_ADDR_W-1:0] rd_addr;
		logic [XLEN-1:0]       rd_data;
		logic                  rd_wen;
		logic                  csr_we;
		logic [CSR_ADDR_W-1:0] csr_waddr;
		logic [XLEN-1:0]       csr_wdata;
		logic                  jump_en;
		logic [XLEN-1:0]       jump_addr;
	} exp_t;

	logic                  clk_i;
	logic                  rst_n_i;
	logic                  in_valid_i;
	logic                  in_ready_o;
	logic [31:0]           inst_i;
	logic [XLEN-1:0]       op1_i;
	logic [XLEN-1:0]       op2_i;
	logic [REG_ADDR_W-1:0] rd_addr_i;
	logic [XLEN-1:0]       base_addr_i;
	logic [XLEN-1:0]       addr_offset_i;
	logic                  csr_we_i;
	logic [CSR_ADDR_W-1:0] csr_waddr_i;
	logic [XLEN-1:0]       csr_rdata_i;
	logic                  int_assert_i;
	logic [XLEN-1:0]       int_addr_i;
	logic                  out_ready_i;
	logic                  out_valid_o;
	logic [REG_ADDR_W-1:0] rd_addr_o;
	logic [XLEN-1:0]       rd_data_o;
	logic                  rd_wen_o;
	logic                  csr_we_o;
	logic [CSR_ADDR_W-1:0] csr_waddr_o;
	logic [XLEN-1:0]       csr_wdata_o;
	logic                  jump_en_o;
	logic [XLEN-1:0]       jump_addr_o;

	integer seed = 25674;
	exp_t   exp_q[$];
	// transfer counters on both sides
	int     in_cnt;
	int     out_cnt;

	ex_stage u_dut (.*);

	always #5 clk_i = ~clk_i;

	task automatic abort_run(input string why);
		$display("*** TEST FAILED ***");
		$fatal(1, "%s", why);
	endtask

	task automatic check_value(input string what, input logic [XLEN-1:0] actual,
			input logic [XLEN-1:0] expected);
		if (actual !== expected) begin
			$display("FAILED at %0t: %s is %h, expected %h", $time, what, actual, expected);
			abort_run("output field does not match the reference");
		end
	endtask

	// random instruction word of one class
	// kind 10 leaves the opcode random
	function automatic logic [31:0] make_inst(input int kind);
		logic [31:0] w;
		logic [1:0]  pick;
		w    = $random(seed);
		pick = $random(seed);
		case (kind)
			0, 2: begin
				w[6:0] = (kind == 0) ? OPC_OP : OPC_OP_32;
				// mostly legal funct7 with an occasional m-extension code
				w[31:25] = (pick == 2'd0) ? 7'h01 : (pick[0] ? FUNCT7_ALT : FUNCT7_BASE);
			end
			1, 3: begin
				w[6:0] = (kind == 1) ? OPC_OP_IMM : OPC_OP_IMM_32;
				// logical or arithmetic shift encodings
				if (pick != 2'd0)
					w[31:25] = pick[0] ? FUNCT7_ALT : FUNCT7_BASE;
			end
			4: w[6:0] = OPC_LUI;
			5: w[6:0] = OPC_AUIPC;
			6: w[6:0] = OPC_BRANCH;
			7: w[6:0] = OPC_JAL;
			8: begin
				w[6:0] = OPC_JALR;
				if (pick != 2'd0)
					w[14:12] = 3'b000;
			end
			9: w[6:0] = OPC_SYSTEM;
			default: ;
		endcase
		return w;
	endfunction

	// drive one transaction and wait for it to be taken
	task automatic send_random_txn();
		int waited;
		int target;
		waited        = 0;
		target        = in_cnt + 1;
		inst_i        = make_inst({$random(seed)} % 11);
		op1_i         = {$random(seed), $random(seed)};
		op2_i         = {$random(seed), $random(seed)};
		// equal operands now and then for beq and bge
		if (({$random(seed)} % 8) == 0)
			op2_i = op1_i;
		rd_addr_i     = $random(seed);
		base_addr_i   = {$random(seed), $random(seed)};
		addr_offset_i = {$random(seed), $random(seed)};
		csr_we_i      = $random(seed);
		csr_waddr_i   = $random(seed);
		csr_rdata_i   = {$random(seed), $random(seed)};
		int_assert_i  = (({$random(seed)} % 8) == 0);
		int_addr_i    = {$random(seed), $random(seed)};
		in_valid_i    = 1'b1;
		out_ready_i   = (({$random(seed)} % 4) != 0);
		do begin
			@(negedge clk_i);
			out_ready_i = (({$random(seed)} % 4) != 0);
			waited++;
			if (waited > WAIT_LIMIT)
				abort_run("input handshake timed out, in_ready_o stayed low");
		end while (in_cnt != target);
	endtask

	task automatic idle_cycle();
		in_valid_i = 1'b0;
		@(negedge clk_i);
		out_ready_i = (({$random(seed)} % 4) != 0);
	endtask

	// reference result for every accepted input
	always @(posedge clk_i) begin : push_expected
		exp_t e;
		if (rst_n_i && in_valid_i && in_ready_o) begin
			e.rd_addr   = rd_addr_i;
			e.csr_waddr = csr_waddr_i;
			ex_ref_result(inst_i, op1_i, op2_i, base_addr_i, addr_offset_i, csr_rdata_i,
				csr_we_i, int_assert_i, int_addr_i, e.rd_wen, e.rd_data, e.csr_we,
				e.csr_wdata, e.jump_en, e.jump_addr);
			exp_q.push_back(e);
			in_cnt++;
		end
	end

	// compare on every output transfer
	always @(posedge clk_i) begin : compare_output
		exp_t e;
		if (rst_n_i && out_valid_o && out_ready_i) begin
			if (exp_q.size() == 0)
				abort_run("output transfer with no pending transaction");
			e = exp_q.pop_front();
			check_value("rd_addr_o", rd_addr_o, e.rd_addr);
			check_value("rd_data_o", rd_data_o, e.rd_data);
			check_value("rd_wen_o", rd_wen_o, e.rd_wen);
			check_value("csr_we_o", csr_we_o, e.csr_we);
			check_value("csr_waddr_o", csr_waddr_o, e.csr_waddr);
			check_value("csr_wdata_o", csr_wdata_o, e.csr_wdata);
			check_value("jump_en_o", jump_en_o, e.jump_en);
			check_value("jump_addr_o", jump_addr_o, e.jump_addr);
			out_cnt++;
		end
	end

	initial begin
		int waited;
		clk_i         = 1'b0;
		rst_n_i       = 1'b0;
		in_valid_i    = 1'b0;
		inst_i        = '0;
		op1_i         = '0;
		op2_i         = '0;
		rd_addr_i     = '0;
		base_addr_i   = '0;
		addr_offset_i = '0;
		csr_we_i      = 1'b0;
		csr_waddr_i   = '0;
		csr_rdata_i   = '0;
		int_assert_i  = 1'b0;
		int_addr_i    = '0;
		out_ready_i   = 1'b0;
		in_cnt        = 0;
		out_cnt       = 0;
		repeat (16) @(posedge clk_i);
		@(negedge clk_i);
		rst_n_i = 1'b1;
		// nothing pending before the first input
		repeat (3) begin
			@(negedge clk_i);
			check_value("out_valid_o after reset", out_valid_o, '0);
			check_value("rd_wen_o after reset", rd_wen_o, '0);
			check_value("csr_we_o after reset", csr_we_o, '0);
			check_value("jump_en_o after reset", jump_en_o, '0);
		end
		for (int n = 0; n < NUM_TXN; n++) begin
			if (({$random(seed)} % 4) == 0)
				idle_cycle();
			send_random_txn();
		end
		in_valid_i  = 1'b0;
		out_ready_i = 1'b1;
		// let the last result leave
		waited = 0;
		while (out_valid_o || exp_q.size() != 0) begin
			@(negedge clk_i);
			waited++;
			if (waited > WAIT_LIMIT)
				abort_run("output register did not drain at end of run");
		end
		repeat (4) @(negedge clk_i);
		if (exp_q.size() != 0 || out_cnt != in_cnt || in_cnt != NUM_TXN) begin
			$display("transactions lost or duplicated: %0d in, %0d out", in_cnt, out_cnt);
			$display("*** TEST FAILED ***");
			$fatal(1, "transaction count mismatch at end of run");
		end else begin
			$display("*** TEST PASSED ***");
			$finish;
		end
	end

endmodule
